// File: Bender.yml
package:
  name: icache

sources:
  - src/icache_pkg.sv
  - src/icache_refill_if.sv
  - src/icache_way_ram.sv
  - src/icache_victim_sel.sv
  - src/icache_lookup.sv
  - src/icache_refill.sv
  - src/icache_top.sv
  - target: simulation
    files:
      - tb/icache_axi_mem.sv
      - tb/icache_tb.sv

// File: build.f
src/icache_pkg.sv
src/icache_refill_if.sv
src/icache_way_ram.sv
src/icache_victim_sel.sv
src/icache_lookup.sv
src/icache_refill.sv
src/icache_top.sv
tb/icache_axi_mem.sv
tb/icache_tb.sv

// File: src/icache_lookup.sv
`timescale 1ns/1ps

module icache_lookup #(
    parameter int NUM_WAYS = 4
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    req_valid,
    input  icache_pkg::fetch_addr_t req_addr,
    output logic                    req_ready,

    output logic                    resp_valid,
    output logic [63:0]             resp_data,
    input  logic                    resp_ready,

    input  logic [NUM_WAYS-1:0]     victim_way,
    output logic [NUM_WAYS-1:0]     set_valid,

    icache_refill_if.sink           refill
);

    logic                    sweep_active;
    icache_pkg::index_t      sweep_index;
    logic                    look_valid;
    icache_pkg::fetch_addr_t look_addr;
    logic                    miss_pend;
    logic                    replay;
    logic [NUM_WAYS-1:0]     victim_q;
    logic [NUM_WAYS-1:0]     hit;
    logic                    look_miss;
    logic                    advance;
    logic                    resp_free;
    logic                    accept;
    logic                    rd_en;
    icache_pkg::index_t      rd_index;
    icache_pkg::index_t      wr_index;
    icache_pkg::tag_t        way_tag  [NUM_WAYS];
    icache_pkg::line_t       way_line [NUM_WAYS];
    icache_pkg::line_t       hit_line;
    logic [2:0]              word_hi;

    assign resp_free = !resp_valid || resp_ready;
    assign look_miss = look_valid && !(|hit);
    assign advance   = look_valid && (|hit) && resp_free;
    assign req_ready = !sweep_active && !miss_pend && !replay && !look_miss && resp_free;
    assign accept    = req_valid && req_ready;

    // replay rereads the missed set once the line is written
    assign rd_en    = accept || replay;
    assign rd_index = replay ? look_addr.f.index : req_addr.f.index;
    assign wr_index = sweep_active ? sweep_index : refill.fill_index;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        icache_way_ram u_way_ram (
            .clk      (clk),
            .rd_en    (rd_en),
            .rd_index (rd_index),
            .rd_valid (set_valid[w]),
            .rd_tag   (way_tag[w]),
            .rd_line  (way_line[w]),
            .wr_en    (sweep_active || (refill.fill_valid && victim_q[w])),
            .wr_index (wr_index),
            .wr_valid (!sweep_active),
            .wr_tag   (refill.fill_tag),
            .wr_line  (refill.fill_line)
        );

        assign hit[w] = set_valid[w] && (way_tag[w] == look_addr.f.tag);
    end

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit[w]) begin
                hit_line = hit_line | way_line[w];
            end
        end
    end

    assign word_hi = look_addr.f.word_off + 3'd1;

    // clear one set per cycle after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            sweep_active <= 1'b1;
            sweep_index  <= '0;
        end else if (sweep_active) begin
            sweep_index <= sweep_index + 1'b1;
            if (sweep_index == icache_pkg::index_t'(icache_pkg::NUM_SETS - 1)) begin
                sweep_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            look_valid <= 1'b0;
            miss_pend  <= 1'b0;
            replay     <= 1'b0;
        end else begin
            replay <= refill.fill_valid;
            if (refill.fill_valid) begin
                miss_pend <= 1'b0;
            end else if (look_miss) begin
                miss_pend <= 1'b1;
            end
            if (accept || replay) begin
                look_valid <= 1'b1;
            end else if (look_miss || advance) begin
                look_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            look_addr <= req_addr;
        end
        if (look_miss) begin
            victim_q <= victim_way;
        end
    end

    // response stage
    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else if (advance) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            resp_data <= {hit_line[word_hi], hit_line[look_addr.f.word_off]};
        end
    end

    assign refill.miss_valid = miss_pend;
    assign refill.miss_addr  = look_addr;

    // a refilled line must never duplicate a resident tag
    a_one_hit: assert property (@(posedge clk) disable iff (reset)
        look_valid |-> $onehot0(hit));

    a_resp_hold: assert property (@(posedge clk) disable iff (reset)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data));

endmodule

// File: src/icache_pkg.sv
package icache_pkg;

    // fetch address and AXI beat
    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;

    // cache geometry
    localparam int LINE_WORDS   = 8;
    localparam int NUM_SETS     = 128;
    localparam int INDEX_WIDTH  = $clog2(NUM_SETS);
    localparam int OFFSET_WIDTH = $clog2(LINE_WORDS * WORD_WIDTH / 8);
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    typedef logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] line_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;

    // raw for the bus side, fields for the lookup side
    typedef struct packed {
        tag_t       tag;
        index_t     index;
        logic [2:0] word_off;
        logic [1:0] byte_off;
    } fetch_fields_t;

    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        fetch_fields_t         f;
    } fetch_addr_t;

    // AR channel codes for one line refill
    localparam logic [7:0] AXI_LEN_LINE   = 8'(LINE_WORDS - 1);
    localparam logic [2:0] AXI_SIZE_WORD  = 3'd2;
    localparam logic [1:0] AXI_BURST_INCR = 2'd1;

endpackage

// File: src/icache_refill.sv
`timescale 1ns/1ps

module icache_refill (
    input  logic                              clk,
    input  logic                              reset,

    // AR channel
    output logic                              arvalid,
    input  logic                              arready,
    output logic [icache_pkg::ADDR_WIDTH-1:0] araddr,
    output logic [7:0]                        arlen,
    output logic [2:0]                        arsize,
    output logic [1:0]                        arburst,

    // R channel
    input  logic                              rvalid,
    output logic                              rready,
    input  logic [icache_pkg::WORD_WIDTH-1:0] rdata,
    input  logic                              rlast,

    icache_refill_if.source                   refill
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_ADDR = 2'd1;
    localparam logic [1:0] S_READ = 2'd2;

    localparam int BEAT_BITS = $clog2(icache_pkg::LINE_WORDS);

    logic [1:0]              state;
    icache_pkg::fetch_addr_t line_addr;
    logic [BEAT_BITS-1:0]    beat_cnt;
    icache_pkg::line_t       line_buf;
    logic                    fill_valid;
    logic                    beat;

    assign beat = (state == S_READ) && rvalid && rready;

    // miss_valid is still high during the fill pulse, so skip that cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            fill_valid <= 1'b0;
            beat_cnt   <= '0;
        end else begin
            fill_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (refill.miss_valid && !fill_valid) begin
                        state <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (arready) begin
                        state    <= S_READ;
                        beat_cnt <= '0;
                    end
                end
                S_READ: begin
                    if (beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (rlast) begin
                            state      <= S_IDLE;
                            fill_valid <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // line-aligned copy of the missed address
    always_ff @(posedge clk) begin
        if (state == S_IDLE && refill.miss_valid && !fill_valid) begin
            line_addr.raw <= {refill.miss_addr.raw[icache_pkg::ADDR_WIDTH-1:
                                                   icache_pkg::OFFSET_WIDTH],
                              {icache_pkg::OFFSET_WIDTH{1'b0}}};
        end
    end

    // beats arrive in address order for an incrementing burst
    always_ff @(posedge clk) begin
        if (beat) begin
            line_buf[beat_cnt] <= rdata;
        end
    end

    assign arvalid = (state == S_ADDR);
    assign araddr  = line_addr.raw;
    assign arlen   = icache_pkg::AXI_LEN_LINE;
    assign arsize  = icache_pkg::AXI_SIZE_WORD;
    assign arburst = icache_pkg::AXI_BURST_INCR;

    // R channel never stalls
    assign rready = 1'b1;

    assign refill.fill_valid = fill_valid;
    assign refill.fill_index = line_addr.f.index;
    assign refill.fill_tag   = line_addr.f.tag;
    assign refill.fill_line  = line_buf;

    a_ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr));

    // memory must end the burst on the last word of the line
    a_rlast_beat: assert property (@(posedge clk) disable iff (reset)
        beat |-> (rlast == (beat_cnt == BEAT_BITS'(icache_pkg::LINE_WORDS - 1))));

endmodule

// File: src/icache_refill_if.sv
`timescale 1ns/1ps

interface icache_refill_if;

    // miss request from the lookup
    logic                    miss_valid;
    icache_pkg::fetch_addr_t miss_addr;

    // finished line, one cycle wide
    logic                    fill_valid;
    icache_pkg::index_t      fill_index;
    icache_pkg::tag_t        fill_tag;
    icache_pkg::line_t       fill_line;

    modport source (
        input  miss_valid, miss_addr,
        output fill_valid, fill_index, fill_tag, fill_line
    );

    modport sink (
        output miss_valid, miss_addr,
        input  fill_valid, fill_index, fill_tag, fill_line
    );

endinterface

// File: src/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
    parameter int NUM_WAYS = 4
) (
    input  logic                              clk,
    input  logic                              reset,

    // fetch request
    input  logic                              req_valid,
    input  icache_pkg::fetch_addr_t           req_addr,
    output logic                              req_ready,

    // fetch response, word pair
    output logic                              resp_valid,
    output logic [63:0]                       resp_data,
    input  logic                              resp_ready,

    // AXI read address
    output logic                              arvalid,
    input  logic                              arready,
    output logic [icache_pkg::ADDR_WIDTH-1:0] araddr,
    output logic [7:0]                        arlen,
    output logic [2:0]                        arsize,
    output logic [1:0]                        arburst,

    // AXI read data
    input  logic                              rvalid,
    output logic                              rready,
    input  logic [icache_pkg::WORD_WIDTH-1:0] rdata,
    input  logic                              rlast
);

    logic [NUM_WAYS-1:0] set_valid;
    logic [NUM_WAYS-1:0] victim_way;

    icache_refill_if u_refill_if ();

    icache_lookup #(
        .NUM_WAYS (NUM_WAYS)
    ) u_lookup (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_ready (resp_ready),
        .victim_way (victim_way),
        .set_valid  (set_valid),
        .refill     (u_refill_if.sink)
    );

    icache_victim_sel #(
        .NUM_WAYS (NUM_WAYS)
    ) u_victim_sel (
        .clk        (clk),
        .reset      (reset),
        .set_valid  (set_valid),
        .victim_way (victim_way)
    );

    icache_refill u_refill (
        .clk     (clk),
        .reset   (reset),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rlast   (rlast),
        .refill  (u_refill_if.source)
    );

endmodule

// File: src/icache_victim_sel.sv
`timescale 1ns/1ps

module icache_victim_sel #(
    parameter int NUM_WAYS = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [NUM_WAYS-1:0] set_valid,
    // one-hot
    output logic [NUM_WAYS-1:0] victim_way
);

    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    logic [7:0]          lfsr;
    logic [NUM_WAYS-1:0] invalid;
    logic [NUM_WAYS-1:0] first_invalid;
    logic [NUM_WAYS-1:0] rand_way;

    // x^8 + x^6 + x^5 + x^4 + 1, must not start at zero
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= 8'ha5;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    assign invalid = ~set_valid;

    // isolate the lowest set bit
    assign first_invalid = invalid & (~invalid + 1'b1);

    assign rand_way = NUM_WAYS'(1) << lfsr[WAY_BITS-1:0];

    // full set falls back to the random way
    assign victim_way = (|invalid) ? first_invalid : rand_way;

endmodule

// File: src/icache_way_ram.sv
`timescale 1ns/1ps

module icache_way_ram (
    input  logic               clk,

    input  logic               rd_en,
    input  icache_pkg::index_t rd_index,
    output logic               rd_valid,
    output icache_pkg::tag_t   rd_tag,
    output icache_pkg::line_t  rd_line,

    input  logic               wr_en,
    input  icache_pkg::index_t wr_index,
    input  logic               wr_valid,
    input  icache_pkg::tag_t   wr_tag,
    input  icache_pkg::line_t  wr_line
);

    logic              valid_mem [icache_pkg::NUM_SETS];
    icache_pkg::tag_t  tag_mem   [icache_pkg::NUM_SETS];
    icache_pkg::line_t line_mem  [icache_pkg::NUM_SETS];

    // write port, used by the refill and by the valid sweep
    always_ff @(posedge clk) begin
        if (wr_en) begin
            valid_mem[wr_index] <= wr_valid;
            tag_mem[wr_index]   <= wr_tag;
            line_mem[wr_index]  <= wr_line;
        end
    end

    // read port holds its output while disabled
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_valid <= valid_mem[rd_index];
            rd_tag   <= tag_mem[rd_index];
            rd_line  <= line_mem[rd_index];
        end
    end

endmodule

// File: tb/icache_axi_mem.sv
`timescale 1ns/1ps

module icache_axi_mem #(
    parameter logic [31:0] DATA_KEY = 32'h0
) (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              arvalid,
    output logic                              arready,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] araddr,
    input  logic [7:0]                        arlen,

    output logic                              rvalid,
    input  logic                              rready,
    output logic [icache_pkg::WORD_WIDTH-1:0] rdata,
    output logic                              rlast
);

    logic [icache_pkg::ADDR_WIDTH-1:0] burst_addr;
    int                                beats_left;

    initial begin
        arready    = 1'b0;
        rvalid     = 1'b0;
        rdata      = '0;
        rlast      = 1'b0;
        burst_addr = '0;
        beats_left = 0;
    end

    // handshakes seen on the rising edge
    always @(posedge clk) begin
        if (reset) begin
            beats_left <= 0;
        end else if (arvalid && arready) begin
            burst_addr <= araddr;
            beats_left <= int'(arlen) + 1;
        end else if (rvalid && rready) begin
            burst_addr <= burst_addr + 32'd4;
            beats_left <= beats_left - 1;
        end
    end

    // random gaps on both channels
    always @(negedge clk) begin
        arready <= (beats_left == 0) && ($urandom_range(0, 3) != 0);
        // a beat not yet taken stays on the bus
        if (!(rvalid && !rready)) begin
            if (beats_left != 0 && $urandom_range(0, 2) != 0) begin
                rvalid <= 1'b1;
                rdata  <= burst_addr ^ DATA_KEY;
                rlast  <= (beats_left == 1);
            end else begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
            end
        end
    end

endmodule

// File: tb/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam int          NUM_WAYS = 4;
    localparam int          NUM_REQS = 400;
    localparam int          MAX_WAIT = 500;
    localparam logic [31:0] DATA_KEY = 32'h5a3c_96e1;

    logic                              clk;
    logic                              reset;
    logic                              req_valid;
    icache_pkg::fetch_addr_t           req_addr;
    logic                              req_ready;
    logic                              resp_valid;
    logic [63:0]                       resp_data;
    logic                              resp_ready;
    logic                              arvalid;
    logic                              arready;
    logic [icache_pkg::ADDR_WIDTH-1:0] araddr;
    logic [7:0]                        arlen;
    logic [2:0]                        arsize;
    logic [1:0]                        arburst;
    logic                              rvalid;
    logic                              rready;
    logic [icache_pkg::WORD_WIDTH-1:0] rdata;
    logic                              rlast;

    logic [63:0] exp_q[$];
    bit          req_lines[int];
    bit          ar_lines[int];
    int          errors;
    int          req_count;
    int          resp_count;
    int          ar_count;
    bit          timed_out;

    // few sets, so lines collide and refill into every way
    icache_pkg::index_t set_pool[4] = '{7'd3, 7'd17, 7'd64, 7'd127};

    icache_top #(
        .NUM_WAYS (NUM_WAYS)
    ) u_icache_top (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_ready (resp_ready),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .arlen      (arlen),
        .arsize     (arsize),
        .arburst    (arburst),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rlast      (rlast)
    );

    icache_axi_mem #(
        .DATA_KEY (DATA_KEY)
    ) u_axi_mem (
        .clk     (clk),
        .reset   (reset),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arlen   (arlen),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rlast   (rlast)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // memory content as a function of the byte address
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return addr ^ DATA_KEY;
    endfunction

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout while waiting for %s at %0t", what, $time);
    endtask

    task automatic check_idle_outputs();
        assert (!resp_valid && !arvalid) else begin
            errors++;
            $display("mismatch at %0t: resp_valid or arvalid high around reset", $time);
        end
    endtask

    task automatic send_request(input icache_pkg::fetch_addr_t addr);
        int waited;
        waited    = 0;
        req_valid = 1'b1;
        req_addr  = addr;
        @(posedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > MAX_WAIT) begin
                report_timeout("req_ready");
                break;
            end
            @(posedge clk);
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        resp_ready <= ($urandom_range(0, 2) != 0);
    end

    // scoreboard and AR monitor
    always @(posedge clk) begin
        logic [63:0] expected;
        int          line;
        if (!reset) begin
            if (resp_valid && resp_ready) begin
                resp_count++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("response at %0t with no request outstanding", $time);
                end else begin
                    expected = exp_q.pop_front();
                    assert (resp_data == expected) else begin
                        errors++;
                        $display("mismatch at %0t: resp_data %h, expected %h",
                                 $time, resp_data, expected);
                    end
                end
            end
            if (req_valid && req_ready) begin
                req_count++;
                exp_q.push_back({word_at(req_addr.raw + 32'd4), word_at(req_addr.raw)});
            end
            if (arvalid && arready) begin
                ar_count++;
                line = int'(araddr >> icache_pkg::OFFSET_WIDTH);
                // each requested line is fetched exactly once
                assert (req_lines.exists(line) && !ar_lines.exists(line)) else begin
                    errors++;
                    $display("mismatch at %0t: unexpected burst for line %h", $time, araddr);
                end
                ar_lines[line] = 1'b1;
            end
        end
    end

    a_resp_stable: assert property (@(posedge clk) disable iff (reset)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data))
        else begin
            errors++;
            $display("mismatch at %0t: response dropped or changed before transfer", $time);
        end

    a_ar_shape: assert property (@(posedge clk) disable iff (reset)
        arvalid |-> araddr[icache_pkg::OFFSET_WIDTH-1:0] == '0
            && arlen == icache_pkg::AXI_LEN_LINE && arsize == icache_pkg::AXI_SIZE_WORD
            && arburst == icache_pkg::AXI_BURST_INCR)
        else begin
            errors++;
            $display("mismatch at %0t: AR payload %h len %0d size %0d burst %0d",
                     $time, araddr, arlen, arsize, arburst);
        end

    // the cache never stalls the R channel
    a_rready_high: assert property (@(posedge clk) disable iff (reset)
        rready)
        else begin
            errors++;
            $display("mismatch at %0t: rready low", $time);
        end

    initial begin
        icache_pkg::fetch_addr_t addr;
        int                      waited;
        void'($urandom(95129));
        errors     = 0;
        req_count  = 0;
        resp_count = 0;
        ar_count   = 0;
        timed_out  = 1'b0;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        resp_ready = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_idle_outputs();
        end
        reset = 1'b0;
        @(negedge clk);
        check_idle_outputs();

        // at most NUM_WAYS tags per set, 8-byte aligned fetches
        for (int i = 0; i < NUM_REQS && !timed_out; i++) begin
            addr.f.tag      = icache_pkg::tag_t'(20'h1a0 + $urandom_range(0, NUM_WAYS - 1));
            addr.f.index    = set_pool[$urandom_range(0, 3)];
            addr.f.word_off = 3'($urandom_range(0, 3) * 2);
            addr.f.byte_off = 2'd0;
            req_lines[int'(addr.raw >> icache_pkg::OFFSET_WIDTH)] = 1'b1;
            send_request(addr);
            repeat ($urandom_range(0, 2)) @(negedge clk);
        end

        waited = 0;
        while (!timed_out && exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > MAX_WAIT) begin
                report_timeout("outstanding responses");
            end
        end

        if (!timed_out) begin
            assert (ar_count == req_lines.num()) else begin
                errors++;
                $display("mismatch at %0t: %0d bursts for %0d distinct lines",
                         $time, ar_count, req_lines.num());
            end
        end

        $display("errors: %0d  requests: %0d  responses: %0d  bursts: %0d",
                 errors, req_count, resp_count, ar_count);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
